//--- source/mem_pkg.sv
`default_nettype none

package mem_pkg;

   localparam int DATA_WIDTH     = 32;
   localparam int REG_ADDR_WIDTH = 5;
   localparam int MEM_ADDR_WIDTH = 10;   // Byte address bits decoded by the RAM
   localparam int BE_WIDTH       = 4;
   localparam int MEM_WORDS      = 2 ** (MEM_ADDR_WIDTH - 2);

   typedef logic [DATA_WIDTH-1:0]     data_t;
   typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
   typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
   typedef logic [BE_WIDTH-1:0]       be_t;

   localparam data_t FETCH_BASE = '0;    // First instruction byte address

   typedef enum logic [2:0]
   {
      LD_B,
      LD_H,
      LD_W,
      LD_BU,
      LD_HU
   } load_op_e;

   // Tracks one access through grant and rvalid
   typedef enum logic [1:0]
   {
      LSU_IDLE,
      LSU_READ,
      LSU_WRITE
   } lsu_state_e;

endpackage

`default_nettype wire

//--- source/core_mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module core_mem_stage
(
   input  wire                  clk,
   input  wire                  rst_n,
   input  wire mem_pkg::reg_addr_t m_regfile_waddr_i,
   input  wire mem_pkg::data_t  m_regfile_rd_i,
   input  wire                  m_regfile_wr_i,
   input  wire mem_pkg::data_t  m_data_addr_i,
   input  wire                  m_data_wr_i,
   input  wire                  m_data_rd_i,
   input  wire mem_pkg::be_t    m_data_be_i,
   input  wire                  m_is_load_store_i,
   input  wire mem_pkg::load_op_e m_load_op_i,
   input  wire                  stall_general_i,
   input  wire mem_pkg::data_t  data_rdata_i,
   input  wire                  data_gnt_i,
   input  wire                  data_rvalid_i,
   output mem_pkg::reg_addr_t   w_regfile_waddr_o,
   output mem_pkg::data_t       w_regfile_rd_o,
   output logic                 w_regfile_wr_o,
   output logic                 w_is_load_store_o,
   output mem_pkg::load_op_e    w_load_op_o,
   output logic [1:0]           w_byte_off_o,
   output mem_pkg::data_t       w_data_rdata_o,
   output logic                 w_rvalid_o,
   output logic                 data_req_o,
   output logic                 data_wr_o,
   output mem_pkg::mem_addr_t   data_addr_o,
   output mem_pkg::data_t       data_wdata_o,
   output mem_pkg::be_t         data_be_o
);

   mem_pkg::lsu_state_e state;
   mem_pkg::lsu_state_e next_state;
   logic                read_pending;

   // A read is still waiting for its data
   assign read_pending = (state == mem_pkg::LSU_READ) && !data_rvalid_i;

   assign data_req_o     = (m_data_wr_i | m_data_rd_i) & !read_pending;
   assign data_wr_o      = m_data_wr_i;
   assign data_addr_o    = m_data_addr_i[mem_pkg::MEM_ADDR_WIDTH-1:0];
   assign data_wdata_o   = m_regfile_rd_i;   // Store data comes from the rd operand
   assign data_be_o      = m_data_be_i;
   assign w_data_rdata_o = data_rdata_i;
   assign w_rvalid_o     = data_rvalid_i & (state == mem_pkg::LSU_READ);

   always_comb
   begin
      if (data_req_o && data_gnt_i && m_data_rd_i)
         next_state = mem_pkg::LSU_READ;
      else if (data_req_o && data_gnt_i && m_data_wr_i)
         next_state = mem_pkg::LSU_WRITE;
      else if (read_pending)
         next_state = mem_pkg::LSU_READ;    // Keep waiting for rvalid
      else
         next_state = mem_pkg::LSU_IDLE;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state <= mem_pkg::LSU_IDLE;
      else
         state <= next_state;
   end

   // Flags are held off while the pipeline is stalled
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         w_regfile_wr_o    <= 1'b0;
         w_is_load_store_o <= 1'b0;
      end
      else
      begin
         w_regfile_wr_o    <= m_regfile_wr_i & !stall_general_i;
         w_is_load_store_o <= m_is_load_store_i & !stall_general_i;
      end
   end

   always_ff @(posedge clk)
   begin
      w_regfile_waddr_o <= m_regfile_waddr_i;
      w_regfile_rd_o    <= m_regfile_rd_i;
      w_load_op_o       <= m_load_op_i;
      w_byte_off_o      <= m_data_addr_i[1:0];   // Lane select for the aligner
   end

endmodule

`default_nettype wire

//--- source/load_align.sv
`timescale 1ns/1ns
`default_nettype none

module load_align
(
   input  wire mem_pkg::data_t    w_regfile_rd_i,
   input  wire                    w_regfile_wr_i,
   input  wire                    w_is_load_store_i,
   input  wire mem_pkg::load_op_e w_load_op_i,
   input  wire [1:0]              w_byte_off_i,
   input  wire mem_pkg::data_t    w_data_rdata_i,
   input  wire                    w_rvalid_i,
   output mem_pkg::data_t         wb_data_o,
   output logic                   wb_valid_o
);

   mem_pkg::data_t shifted;
   logic [7:0]     ld_byte;
   logic [15:0]    ld_half;
   mem_pkg::data_t ld_result;

   assign shifted = w_data_rdata_i >> {w_byte_off_i, 3'b000};   // Addressed lane to bit 0
   assign ld_byte = shifted[7:0];
   assign ld_half = shifted[15:0];

   always_comb
   begin
      case (w_load_op_i)
         mem_pkg::LD_B:  ld_result = {{24{ld_byte[7]}}, ld_byte};
         mem_pkg::LD_H:  ld_result = {{16{ld_half[15]}}, ld_half};
         mem_pkg::LD_BU: ld_result = {24'd0, ld_byte};
         mem_pkg::LD_HU: ld_result = {16'd0, ld_half};
         default:        ld_result = w_data_rdata_i;   // Full word
      endcase
   end

   assign wb_data_o  = w_is_load_store_i ? ld_result : w_regfile_rd_i;
   assign wb_valid_o = w_regfile_wr_i & (!w_is_load_store_i | w_rvalid_i);

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
(
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire                 fetch_en_i,
   input  wire                 f_gnt_i,
   input  wire                 f_rvalid_i,
   input  wire mem_pkg::data_t f_rdata_i,
   output logic                f_req_o,
   output mem_pkg::mem_addr_t  f_addr_o,
   output mem_pkg::data_t      instr_o,
   output logic                instr_valid_o
);

   mem_pkg::lsu_state_e state;
   mem_pkg::data_t      pc;
   logic                waiting;

   assign waiting = (state == mem_pkg::LSU_READ) && !f_rvalid_i;

   assign f_req_o       = fetch_en_i & !waiting;
   assign f_addr_o      = pc[mem_pkg::MEM_ADDR_WIDTH-1:0];
   assign instr_o       = f_rdata_i;
   assign instr_valid_o = f_rvalid_i & (state == mem_pkg::LSU_READ);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= mem_pkg::LSU_IDLE;
         pc    <= mem_pkg::FETCH_BASE;
      end
      else
      begin
         if (f_req_o && f_gnt_i)
         begin
            state <= mem_pkg::LSU_READ;
            pc    <= pc + 32'd4;   // Next word only once this one is taken
         end
         else if (!waiting)
            state <= mem_pkg::LSU_IDLE;
      end
   end

endmodule

`default_nettype wire

//--- source/data_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module data_arbiter
(
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     m0_req_i,
   input  wire                     m0_wr_i,
   input  wire mem_pkg::mem_addr_t m0_addr_i,
   input  wire mem_pkg::data_t     m0_wdata_i,
   input  wire mem_pkg::be_t       m0_be_i,
   input  wire                     m1_req_i,
   input  wire mem_pkg::mem_addr_t m1_addr_i,
   input  wire                     ram_gnt_i,
   input  wire                     ram_rvalid_i,
   output logic                    m0_gnt_o,
   output logic                    m1_gnt_o,
   output logic                    m0_rvalid_o,
   output logic                    m1_rvalid_o,
   output logic                    ram_req_o,
   output logic                    ram_wr_o,
   output mem_pkg::mem_addr_t      ram_addr_o,
   output mem_pkg::data_t          ram_wdata_o,
   output mem_pkg::be_t            ram_be_o
);

   logic last_m1;    // Master 1 won the last grant
   logic rd_owner;   // Owner of the read in flight, 1 for master 1
   logic sel_m1;

   // Fetch wins alone, or on a tie when the stage won last
   assign sel_m1 = m1_req_i & (!m0_req_i | !last_m1);

   assign ram_req_o   = m0_req_i | m1_req_i;
   assign ram_wr_o    = sel_m1 ? 1'b0 : m0_wr_i;   // Fetch only reads
   assign ram_addr_o  = sel_m1 ? m1_addr_i : m0_addr_i;
   assign ram_wdata_o = m0_wdata_i;
   assign ram_be_o    = sel_m1 ? '1 : m0_be_i;

   assign m0_gnt_o = ram_gnt_i & m0_req_i & !sel_m1;
   assign m1_gnt_o = ram_gnt_i & sel_m1;

   assign m0_rvalid_o = ram_rvalid_i & !rd_owner;
   assign m1_rvalid_o = ram_rvalid_i & rd_owner;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         last_m1  <= 1'b0;
         rd_owner <= 1'b0;
      end
      else if (ram_req_o && ram_gnt_i)
      begin
         last_m1 <= sel_m1;
         if (!ram_wr_o)
            rd_owner <= sel_m1;
      end
   end

endmodule

`default_nettype wire

//--- source/data_ram.sv
`timescale 1ns/1ns
`default_nettype none

module data_ram
(
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     req_i,
   input  wire                     wr_i,
   input  wire mem_pkg::mem_addr_t addr_i,
   input  wire mem_pkg::data_t     wdata_i,
   input  wire mem_pkg::be_t       be_i,
   output logic                    gnt_o,
   output logic                    rvalid_o,
   output mem_pkg::data_t          rdata_o
);

   mem_pkg::data_t                     mem [mem_pkg::MEM_WORDS];
   logic [mem_pkg::MEM_ADDR_WIDTH-3:0] word_idx;

   assign gnt_o    = req_i;   // Single cycle, never busy
   assign word_idx = addr_i[mem_pkg::MEM_ADDR_WIDTH-1:2];

   always_ff @(posedge clk)
   begin
      if (req_i && wr_i)
      begin
         for (int b = 0; b < mem_pkg::BE_WIDTH; b++)
         begin
            if (be_i[b])
               mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
         end
      end
      if (req_i && !wr_i)
         rdata_o <= mem[word_idx];
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         rvalid_o <= 1'b0;
      else
         rvalid_o <= req_i & !wr_i;
   end

endmodule

`default_nettype wire

//--- source/mem_subsys_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_top
(
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire mem_pkg::reg_addr_t m_regfile_waddr_i,
   input  wire mem_pkg::data_t     m_regfile_rd_i,
   input  wire                     m_regfile_wr_i,
   input  wire mem_pkg::data_t     m_data_addr_i,
   input  wire                     m_data_wr_i,
   input  wire                     m_data_rd_i,
   input  wire mem_pkg::be_t       m_data_be_i,
   input  wire                     m_is_load_store_i,
   input  wire mem_pkg::load_op_e  m_load_op_i,
   input  wire                     stall_general_i,
   input  wire                     fetch_en_i,
   output mem_pkg::reg_addr_t      w_regfile_waddr_o,
   output mem_pkg::data_t          wb_data_o,
   output logic                    wb_valid_o,
   output logic                    mem_gnt_o,
   output mem_pkg::data_t          instr_o,
   output logic                    instr_valid_o
);

   mem_pkg::data_t     w_regfile_rd;
   logic               w_regfile_wr;
   logic               w_is_load_store;
   mem_pkg::load_op_e  w_load_op;
   logic [1:0]         w_byte_off;
   mem_pkg::data_t     w_data_rdata;
   logic               w_rvalid;

   logic               data_req;
   logic               data_wr;
   mem_pkg::mem_addr_t data_addr;
   mem_pkg::data_t     data_wdata;
   mem_pkg::be_t       data_be;
   logic               data_rvalid;

   logic               f_req;
   mem_pkg::mem_addr_t f_addr;
   logic               f_gnt;
   logic               f_rvalid;

   logic               ram_req;
   logic               ram_wr;
   mem_pkg::mem_addr_t ram_addr;
   mem_pkg::data_t     ram_wdata;
   mem_pkg::be_t       ram_be;
   logic               ram_gnt;
   logic               ram_rvalid;
   mem_pkg::data_t     ram_rdata;

   core_mem_stage u_mem_stage
   (
      .clk               (clk),
      .rst_n             (rst_n),
      .m_regfile_waddr_i (m_regfile_waddr_i),
      .m_regfile_rd_i    (m_regfile_rd_i),
      .m_regfile_wr_i    (m_regfile_wr_i),
      .m_data_addr_i     (m_data_addr_i),
      .m_data_wr_i       (m_data_wr_i),
      .m_data_rd_i       (m_data_rd_i),
      .m_data_be_i       (m_data_be_i),
      .m_is_load_store_i (m_is_load_store_i),
      .m_load_op_i       (m_load_op_i),
      .stall_general_i   (stall_general_i),
      .data_rdata_i      (ram_rdata),
      .data_gnt_i        (mem_gnt_o),
      .data_rvalid_i     (data_rvalid),
      .w_regfile_waddr_o (w_regfile_waddr_o),
      .w_regfile_rd_o    (w_regfile_rd),
      .w_regfile_wr_o    (w_regfile_wr),
      .w_is_load_store_o (w_is_load_store),
      .w_load_op_o       (w_load_op),
      .w_byte_off_o      (w_byte_off),
      .w_data_rdata_o    (w_data_rdata),
      .w_rvalid_o        (w_rvalid),
      .data_req_o        (data_req),
      .data_wr_o         (data_wr),
      .data_addr_o       (data_addr),
      .data_wdata_o      (data_wdata),
      .data_be_o         (data_be)
   );

   load_align u_load_align
   (
      .w_regfile_rd_i    (w_regfile_rd),
      .w_regfile_wr_i    (w_regfile_wr),
      .w_is_load_store_i (w_is_load_store),
      .w_load_op_i       (w_load_op),
      .w_byte_off_i      (w_byte_off),
      .w_data_rdata_i    (w_data_rdata),
      .w_rvalid_i        (w_rvalid),
      .wb_data_o         (wb_data_o),
      .wb_valid_o        (wb_valid_o)
   );

   fetch_unit u_fetch
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .fetch_en_i    (fetch_en_i),
      .f_gnt_i       (f_gnt),
      .f_rvalid_i    (f_rvalid),
      .f_rdata_i     (ram_rdata),   // Read data fans out to both masters
      .f_req_o       (f_req),
      .f_addr_o      (f_addr),
      .instr_o       (instr_o),
      .instr_valid_o (instr_valid_o)
   );

   data_arbiter u_arbiter
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .m0_req_i     (data_req),
      .m0_wr_i      (data_wr),
      .m0_addr_i    (data_addr),
      .m0_wdata_i   (data_wdata),
      .m0_be_i      (data_be),
      .m1_req_i     (f_req),
      .m1_addr_i    (f_addr),
      .ram_gnt_i    (ram_gnt),
      .ram_rvalid_i (ram_rvalid),
      .m0_gnt_o     (mem_gnt_o),
      .m1_gnt_o     (f_gnt),
      .m0_rvalid_o  (data_rvalid),
      .m1_rvalid_o  (f_rvalid),
      .ram_req_o    (ram_req),
      .ram_wr_o     (ram_wr),
      .ram_addr_o   (ram_addr),
      .ram_wdata_o  (ram_wdata),
      .ram_be_o     (ram_be)
   );

   data_ram u_ram
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .req_i    (ram_req),
      .wr_i     (ram_wr),
      .addr_i   (ram_addr),
      .wdata_i  (ram_wdata),
      .be_i     (ram_be),
      .gnt_o    (ram_gnt),
      .rvalid_o (ram_rvalid),
      .rdata_o  (ram_rdata)
   );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;   // Release just after the third edge
   end

endmodule

`default_nettype wire

//--- dv/tb_mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_subsys;

   localparam int MAX_LINES   = 64;
   localparam int K_STORE     = 0;
   localparam int K_LOAD      = 1;
   localparam int K_ALU       = 2;
   localparam int K_FETCH_EXP = 3;
   localparam int K_FETCH_ON  = 4;
   localparam int K_FETCH_OFF = 5;

   logic               clk;
   logic               rst_n;
   mem_pkg::reg_addr_t m_regfile_waddr;
   mem_pkg::data_t     m_regfile_rd;
   logic               m_regfile_wr;
   mem_pkg::data_t     m_data_addr;
   logic               m_data_wr;
   logic               m_data_rd;
   mem_pkg::be_t       m_data_be;
   logic               m_is_load_store;
   mem_pkg::load_op_e  m_load_op;
   logic               stall_general;
   logic               fetch_en;
   mem_pkg::reg_addr_t w_regfile_waddr;
   mem_pkg::data_t     wb_data;
   logic               wb_valid;
   logic               mem_gnt;
   mem_pkg::data_t     instr;
   logic               instr_valid;

   // One entry per stimulus line
   int          st_kind  [MAX_LINES];
   logic [31:0] st_addr  [MAX_LINES];
   logic [31:0] st_wdata [MAX_LINES];
   logic [3:0]  st_be    [MAX_LINES];
   logic [2:0]  st_op    [MAX_LINES];
   logic [4:0]  st_rd    [MAX_LINES];
   logic        st_stall [MAX_LINES];
   logic [31:0] st_exp   [MAX_LINES];
   int          n_lines = 0;

   mem_pkg::data_t fetch_exp [$];   // Instruction words in fetch order
   int             fetch_seen   = 0;
   int             fetch_errors = 0;
   int             test_errors  = 0;
   int             pass_count   = 0;
   int             fail_count   = 0;
   int             cycles       = 0;
   int             limit        = 0;

   tb_clk_gen u_clk_gen
   (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mem_subsys_top uut
   (
      .clk               (clk),
      .rst_n             (rst_n),
      .m_regfile_waddr_i (m_regfile_waddr),
      .m_regfile_rd_i    (m_regfile_rd),
      .m_regfile_wr_i    (m_regfile_wr),
      .m_data_addr_i     (m_data_addr),
      .m_data_wr_i       (m_data_wr),
      .m_data_rd_i       (m_data_rd),
      .m_data_be_i       (m_data_be),
      .m_is_load_store_i (m_is_load_store),
      .m_load_op_i       (m_load_op),
      .stall_general_i   (stall_general),
      .fetch_en_i        (fetch_en),
      .w_regfile_waddr_o (w_regfile_waddr),
      .wb_data_o         (wb_data),
      .wb_valid_o        (wb_valid),
      .mem_gnt_o         (mem_gnt),
      .instr_o           (instr),
      .instr_valid_o     (instr_valid)
   );

   task automatic load_stim();
      int          fd;
      int          cnt;
      int          kind;
      int          op;
      int          rd;
      int          stall;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] be;
      logic [31:0] expv;
      string       line;
      begin
         fd = $fopen("dv/mem_stim.txt", "r");
         if (fd == 0)
         begin
            $display("Could not open the stimulus file dv/mem_stim.txt");
         end
         else
         begin
            while (!$feof(fd))
            begin
               if ($fgets(line, fd) != 0)
               begin
                  cnt = $sscanf(line, "%d %h %h %h %d %d %d %h",
                                kind, addr, wdata, be, op, rd, stall, expv);
                  if (cnt == 8 && n_lines < MAX_LINES)   // Comment lines fail the scan
                  begin
                     st_kind[n_lines]  = kind;
                     st_addr[n_lines]  = addr;
                     st_wdata[n_lines] = wdata;
                     st_be[n_lines]    = be[3:0];
                     st_op[n_lines]    = op[2:0];
                     st_rd[n_lines]    = rd[4:0];
                     st_stall[n_lines] = stall[0];
                     st_exp[n_lines]   = expv;
                     n_lines++;
                  end
               end
            end
            $fclose(fd);
         end
      end
   endtask

   task automatic drive_idle();
      begin
         m_regfile_waddr = '0;
         m_regfile_rd    = '0;
         m_regfile_wr    = 1'b0;
         m_data_addr     = '0;
         m_data_wr       = 1'b0;
         m_data_rd       = 1'b0;
         m_data_be       = '0;
         m_is_load_store = 1'b0;
         m_load_op       = mem_pkg::LD_W;
         stall_general   = 1'b0;
      end
   endtask

   task automatic drive_op(input int i);
      begin
         m_regfile_waddr = st_rd[i];
         m_regfile_rd    = st_wdata[i];   // Store data or ALU result
         m_regfile_wr    = (st_kind[i] == K_LOAD) || (st_kind[i] == K_ALU);
         m_data_addr     = st_addr[i];
         m_data_wr       = (st_kind[i] == K_STORE);
         m_data_rd       = (st_kind[i] == K_LOAD);
         m_data_be       = st_be[i];
         m_is_load_store = (st_kind[i] == K_STORE) || (st_kind[i] == K_LOAD);
         m_load_op       = mem_pkg::load_op_e'(st_op[i]);
         stall_general   = st_stall[i];
      end
   endtask

   // Hold the request until the stage is granted, stalling the lost cycles
   task automatic issue_mem_op(input int i);
      begin
         drive_op(i);
         #1;
         while (!mem_gnt)
         begin
            stall_general = 1'b1;
            @(posedge clk);
            #1;
            stall_general = st_stall[i];
            #1;
         end
         @(posedge clk);
         #1;
         drive_idle();
      end
   endtask

   task automatic check_writeback(input int i);
      logic expect_valid;
      begin
         expect_valid = ((st_kind[i] == K_LOAD) || (st_kind[i] == K_ALU)) && !st_stall[i];
         if (wb_valid !== expect_valid)
         begin
            $display("ERROR t=%0t wb_valid_o expected %b got %b", $time, expect_valid, wb_valid);
            test_errors++;
         end
         if (expect_valid && wb_data !== st_exp[i])
         begin
            $display("ERROR t=%0t wb_data_o expected %h got %h", $time, st_exp[i], wb_data);
            test_errors++;
         end
         if (expect_valid && w_regfile_waddr !== st_rd[i])
         begin
            $display("ERROR t=%0t w_regfile_waddr_o expected %0d got %0d",
                     $time, st_rd[i], w_regfile_waddr);
            test_errors++;
         end
      end
   endtask

   task automatic report_test(input int i, input string what);
      begin
         if (test_errors == 0)
         begin
            pass_count++;
            $display("%0t: test %0d %s at %h passed", $time, i, what, st_addr[i]);
         end
         else
         begin
            fail_count++;
            $display("%0t: test %0d %s at %h failed", $time, i, what, st_addr[i]);
         end
      end
   endtask

   task automatic run_line(input int i);
      string what;
      begin
         test_errors = 0;
         what = (st_kind[i] == K_STORE) ? "store" : "load";
         case (st_kind[i])
            K_STORE, K_LOAD:
            begin
               issue_mem_op(i);
               check_writeback(i);
               report_test(i, what);
            end
            K_ALU:
            begin
               drive_op(i);
               @(posedge clk);
               #1;
               drive_idle();
               check_writeback(i);
               report_test(i, "alu");
            end
            K_FETCH_EXP: fetch_exp.push_back(st_exp[i]);
            K_FETCH_ON:  fetch_en = 1'b1;
            K_FETCH_OFF:
            begin
               while (fetch_seen < fetch_exp.size())
               begin
                  @(posedge clk);
                  #1;
               end
               fetch_en    = 1'b0;
               test_errors = fetch_errors;
               report_test(i, "fetch");
            end
            default:
            begin
               $display("Stimulus line %0d has an unknown operation kind %0d", i, st_kind[i]);
               test_errors++;
               report_test(i, "unknown");
            end
         endcase
      end
   endtask

   // Fetched words must come back in address order
   always @(negedge clk)
   begin
      if (rst_n && instr_valid && fetch_seen < fetch_exp.size())
      begin
         if (instr !== fetch_exp[fetch_seen])
         begin
            $display("ERROR t=%0t instr_o expected %h got %h", $time, fetch_exp[fetch_seen], instr);
            fetch_errors++;
         end
         fetch_seen++;
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (limit > 0 && cycles >= limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", limit);
         $display("TEST FAIL");
         $finish;
      end
   end

   initial
   begin
      int i;
      void'($urandom(83589));
      drive_idle();
      fetch_en = 1'b0;
      load_stim();
      limit = 40 * n_lines + 200;
      @(posedge clk);
      #1;
      m_regfile_wr = 1'b1;   // Write-back request that reset must hold off
      @(posedge clk);
      #1;
      test_errors = 0;
      if (wb_valid !== 1'b0)
      begin
         $display("ERROR t=%0t wb_valid_o expected 0 got %b", $time, wb_valid);
         test_errors++;
      end
      if (mem_gnt !== 1'b0)
      begin
         $display("ERROR t=%0t mem_gnt_o expected 0 got %b", $time, mem_gnt);
         test_errors++;
      end
      if (instr_valid !== 1'b0)
      begin
         $display("ERROR t=%0t instr_valid_o expected 0 got %b", $time, instr_valid);
         test_errors++;
      end
      report_test(0, "reset");
      drive_idle();
      @(posedge rst_n);
      @(posedge clk);
      #1;
      for (i = 0; i < n_lines; i++)
      begin
         run_line(i);
         repeat ($urandom % 3)   // Idle gap between operations
         begin
            @(posedge clk);
            #1;
         end
      end
      $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
      if (n_lines > 0 && fail_count == 0 && fetch_errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- dv/mem_stim.txt
# kind: 0 store, 1 load, 2 alu, 3 fetch word expected, 4 fetch on, 5 fetch off
# kind addr wdata be load_op(0 B,1 H,2 W,3 BU,4 HU) rd stall expected, hex except op rd stall
0 000 00000013 f 0 0 0 00000000
0 004 00a00093 f 0 0 0 00000000
0 008 fff10113 f 0 0 0 00000000
0 00c 80000237 f 0 0 0 00000000
1 000 00000000 f 2 1 0 00000013
1 00c 00000000 f 2 2 0 80000237
0 010 12345678 f 0 0 0 00000000
0 010 0000c300 2 0 0 0 00000000
0 010 85000000 8 0 0 0 00000000
1 010 00000000 f 2 3 0 8534c378
1 010 00000000 f 0 4 0 00000078
1 011 00000000 f 0 5 0 ffffffc3
1 011 00000000 f 3 6 0 000000c3
1 012 00000000 f 0 7 0 00000034
1 013 00000000 f 0 8 0 ffffff85
1 013 00000000 f 3 9 0 00000085
1 010 00000000 f 1 10 0 ffffc378
1 010 00000000 f 4 11 0 0000c378
1 012 00000000 f 1 12 0 ffff8534
1 012 00000000 f 4 13 0 00008534
0 014 00000000 f 0 0 0 00000000
0 014 deadbeef 3 0 0 0 00000000
1 014 00000000 f 2 14 0 0000beef
2 000 1234abcd 0 0 15 0 1234abcd
2 000 55aa55aa 0 0 16 1 00000000
1 010 00000000 f 2 17 1 00000000
3 000 00000000 0 0 0 0 00000013
3 004 00000000 0 0 0 0 00a00093
3 008 00000000 0 0 0 0 fff10113
3 00c 00000000 0 0 0 0 80000237
4 000 00000000 0 0 0 0 00000000
1 000 00000000 f 2 18 0 00000013
1 011 00000000 f 0 19 0 ffffffc3
1 014 00000000 f 2 20 0 0000beef
1 00e 00000000 f 4 21 0 00008000
0 020 cafef00d f 0 0 0 00000000
1 008 00000000 f 2 22 0 fff10113
5 000 00000000 0 0 0 0 00000000
1 020 00000000 f 2 23 0 cafef00d

//--- flist.f
source/mem_pkg.sv
source/core_mem_stage.sv
source/load_align.sv
source/fetch_unit.sv
source/data_arbiter.sv
source/data_ram.sv
source/mem_subsys_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_mem_subsys -f flist.f -o sim_mem \
   && ./obj_dir/sim_mem > sim.log 2>&1 \
   || { echo "Build or simulation run failed"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation reported failure"; exit 1; } \
   || { grep -q "TEST PASS" sim.log || { echo "No result in sim.log"; exit 1; }; }
exit 0
